// File: compile.f
common/panel_pkg.sv
common/fb_port_if.sv
framebuffer/fb_ram.sv
framebuffer/fb_access.sv
hw/scan_counter.sv
hw/pixel_pwm.sv
hw/panel_driver.sv
hw/led_panel_top.sv
tests/panel_monitor.sv
tests/tb_led_panel.sv

// File: tests/tb_led_panel.sv
`timescale 1ns/1ps

module tb_led_panel import panel_pkg::*; ();

    localparam int table_len      = 12;
    localparam int run_subframes  = 48;
    localparam int row_cycles     = 2 * cols + 3;   // shift, then blank, latch, unblank
    localparam int timeout_cycles =
        (startup_cycles + run_subframes * (1 << row_bits) * row_cycles) * 11 / 10;

    logic                clk;
    logic                pll_locked;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_addr_t           paddr;
    pixel_t              pwdata;
    pixel_t              prdata;
    logic                pready;
    rgb_bits_t           rgb0;
    rgb_bits_t           rgb1;
    logic [row_bits-1:0] row_addr;
    logic                blank;
    logic                latch;
    logic                sclk;

    // stimulus table of address and pixel
    logic [table_len-1:0][$bits(apb_addr_t)-1:0] tbl_addr;
    logic [table_len-1:0][$bits(pixel_t)-1:0]    tbl_pix;
    logic                writes_done;
    logic [31:0]         lfsr;
    int                  cycle_count;
    logic                mon_done;
    int                  mon_tests;
    int                  mon_failed;

    led_panel_top i_led_panel_top (.*);

    panel_monitor #(
        .n_entries   (table_len),
        .n_subframes (run_subframes)
    ) i_panel_monitor (
        .*,
        .done         (mon_done),
        .tests_run    (mon_tests),
        .tests_failed (mon_failed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [15:0] random_pixel();
        logic [15:0] value;
        for (int b = 0; b < 16; b++) begin
            lfsr  = lfsr_step(lfsr);   // one step per bit
            value = {value[14:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic set_entry(input int idx, input apb_addr_t addr, input logic [15:0] pix);
        tbl_addr[idx] = addr;
        tbl_pix[idx]  = pix;
    endtask

    // one APB transfer whose access phase runs until pready
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input pixel_t wdata);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d clock cycles", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        pll_locked  = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        writes_done = 1'b0;
        lfsr        = 32'h5d8a03f1;
        // address is half, row, column
        set_entry(0, {1'b0, 5'd0, 6'd0}, 16'h0000);
        set_entry(1, {1'b0, 5'd0, 6'd63}, 16'hFFFF);
        set_entry(2, {1'b0, 5'd5, 6'd10}, 16'hF800);   // red
        set_entry(3, {1'b1, 5'd5, 6'd10}, 16'h07E0);   // green
        set_entry(4, {1'b1, 5'd31, 6'd63}, 16'h001F);  // blue
        set_entry(5, {1'b0, 5'd12, 6'd33}, random_pixel());
        set_entry(6, {1'b1, 5'd0, 6'd0}, random_pixel());
        set_entry(7, {1'b0, 5'd31, 6'd1}, random_pixel());
        set_entry(8, {1'b1, 5'd17, 6'd40}, random_pixel());
        set_entry(9, {1'b0, 5'd8, 6'd62}, random_pixel());
        set_entry(10, {1'b1, 5'd22, 6'd5}, random_pixel());
        set_entry(11, {1'b1, 5'd3, 6'd31}, random_pixel());
        repeat (10) @(posedge clk);
        #2;
        pll_locked = 1'b1;
        for (int i = 0; i < table_len; i++) begin
            apb_transfer(1'b1, tbl_addr[i], tbl_pix[i]);
        end
        writes_done = 1'b1;
        for (int i = 0; i < table_len; i++) begin
            apb_transfer(1'b0, tbl_addr[i], '0);
        end
        wait (mon_done);
        $display("tests run %0d, passed %0d, failed %0d",
                 mon_tests, mon_tests - mon_failed, mon_failed);
        if (mon_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tests/panel_monitor.sv
`timescale 1ns/1ps

// checks APB readback, scan timing, PWM levels and steal blanking on the DUT pins
module panel_monitor import panel_pkg::*; #(
    parameter int n_entries   = 12,
    parameter int n_subframes = 48
) (
    input  logic                clk,
    input  logic                pll_locked,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_addr_t           paddr,
    input  pixel_t              prdata,
    input  logic                pready,
    input  rgb_bits_t           rgb0,
    input  rgb_bits_t           rgb1,
    input  logic [row_bits-1:0] row_addr,
    input  logic                blank,
    input  logic                latch,
    input  logic                sclk,
    input  logic                writes_done,
    input  logic [n_entries-1:0][$bits(apb_addr_t)-1:0] tbl_addr,
    input  logic [n_entries-1:0][$bits(pixel_t)-1:0]    tbl_pix,
    output logic                done,
    output int                  tests_run,
    output int                  tests_failed
);

    localparam int rows = 1 << row_bits;   // rows per half and latches per subframe

    logic                sclk_q;
    logic                latch_q;
    logic                access_q;      // APB access phase at the last sample
    logic [row_bits-1:0] prev_row;
    int                  post_cycles;   // cycles since reset release
    int                  sclk_count;    // sclk rises since the last latch
    int                  latch_count;
    int                  checks [4];    // startup, scan, pixel, steal
    int                  errs [4];

    // channel widened with zeros below is lit above the reversed count
    function automatic rgb_bits_t expected_bits(logic [15:0] pix, logic [sub_bits-1:0] sub);
        logic [sub_bits-1:0] thr;
        rgb_bits_t           bits;
        for (int i = 0; i < sub_bits; i++) begin
            thr[sub_bits-1-i] = sub[i];
        end
        bits.r = {pix[15:11], 3'b000} > thr;
        bits.g = {pix[10:5], 2'b00} > thr;
        bits.b = {pix[4:0], 3'b000} > thr;
        return bits;
    endfunction

    // a read completes no earlier than the cycle after its RAM read
    task automatic check_read();
        tests_run++;
        if (!access_q) begin
            tests_failed++;
            $display("read of %h completed in its first access cycle, before the RAM read",
                     paddr);
        end else begin
            for (int i = 0; i < n_entries; i++) begin
                if (tbl_addr[i] == paddr) begin
                    if (prdata !== tbl_pix[i]) begin
                        tests_failed++;
                        $display("Fail %0t: read of %h returned %h, expected %h",
                                 $time, paddr, prdata, tbl_pix[i]);
                    end else begin
                        $display("test read %h: holds %h", paddr, prdata);
                    end
                end
            end
        end
    endtask

    task automatic check_column();
        int                  cur_row;
        logic [sub_bits-1:0] sub;
        rgb_bits_t           want;
        rgb_bits_t           seen;
        cur_row = latch_count % rows;
        sub     = sub_bits'(latch_count / rows);
        if (&sub[steal_period_bits-1:0]) begin
            checks[3]++;
            if (rgb0 !== 3'b000 || rgb1 !== 3'b000) begin
                errs[3]++;
                $display("Fail %0t: bits %b/%b lit in stolen subframe %0d",
                         $time, rgb0, rgb1, sub);
            end
        end else if (writes_done) begin
            for (int i = 0; i < n_entries; i++) begin
                if (tbl_addr[i][col_bits +: row_bits] == cur_row
                        && tbl_addr[i][col_bits-1:0] == sclk_count) begin
                    want = expected_bits(tbl_pix[i], sub);
                    seen = tbl_addr[i][row_bits+col_bits] ? rgb1 : rgb0;
                    checks[2]++;
                    if (seen !== want) begin
                        errs[2]++;
                        $display("Fail %0t: pixel at %h in subframe %0d shows %b, expected %b",
                                 $time, tbl_addr[i], sub, seen, want);
                    end
                end
            end
        end
        sclk_count++;
    endtask

    task automatic check_latch();
        logic [row_bits-1:0] want_row;
        want_row   = prev_row + 1'b1;
        checks[1] += 2;
        if (sclk_count != cols) begin
            errs[1]++;
            $display("Fail %0t: %0d sclk rises before latch, expected %0d",
                     $time, sclk_count, cols);
        end
        if (row_addr !== want_row) begin
            errs[1]++;
            $display("Fail %0t: row_addr %0d at latch, expected %0d", $time, row_addr, want_row);
        end
        prev_row   = row_addr;
        sclk_count = 0;
        latch_count++;
    endtask

    task automatic summarize(input string name, input int idx);
        tests_run++;
        if (checks[idx] == 0) begin
            tests_failed++;
            $display("test %s: nothing was checked", name);
        end else if (errs[idx] != 0) begin
            tests_failed++;
            $display("test %s: %0d of %0d checks wrong", name, errs[idx], checks[idx]);
        end else begin
            $display("test %s: %0d checks ok", name, checks[idx]);
        end
    endtask

    initial begin
        done     = 1'b0;
        sclk_q   = 1'b0;
        latch_q  = 1'b0;
        access_q = 1'b0;
        prev_row = '1;   // so the first latch expects row 0
    end

    // sampled on the falling edge when all pins are settled
    always @(negedge clk) begin
        // time 0 is the clock's first value and no real edge
        if ($time > 0 && (!pll_locked || post_cycles < startup_cycles)) begin
            checks[0]++;
            if (blank !== 1'b1 || latch !== 1'b0 || sclk !== 1'b0 || pready !== 1'b0
                    || rgb0 !== 3'b000 || rgb1 !== 3'b000) begin
                errs[0]++;
                $display("Fail %0t: startup pins blank %b latch %b sclk %b pready %b rgb %b/%b",
                         $time, blank, latch, sclk, pready, rgb0, rgb1);
            end
        end
        if (pll_locked && !done) begin
            post_cycles++;
            if (psel && penable && !pwrite && pready) check_read();
            if (sclk && !sclk_q) check_column();
            if (latch && !latch_q) check_latch();
            if (latch_count == n_subframes * rows) begin
                summarize("startup pins", 0);
                summarize("scan timing", 1);
                summarize("pixel pwm", 2);
                summarize("steal blanking", 3);
                done = 1'b1;
            end
        end
        sclk_q   = sclk;
        latch_q  = latch;
        access_q = psel && penable;
    end

endmodule

// File: hw/led_panel_top.sv
`timescale 1ns/1ps

module led_panel_top import panel_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,

    // APB slave to the frame buffer
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_addr_t           paddr,
    input  pixel_t              pwdata,
    output pixel_t              prdata,
    output logic                pready,

    // HUB75 panel
    output rgb_bits_t           rgb0,
    output rgb_bits_t           rgb1,
    output logic [row_bits-1:0] row_addr,
    output logic                blank,
    output logic                latch,
    output logic                sclk
);

    fb_addr_t            scan_addr;
    logic [row_bits-1:0] row;
    logic                steal;
    logic [sub_bits-1:0] threshold;
    logic                step;
    pixel_t              pix0;
    pixel_t              pix1;
    rgb_bits_t           pwm_rgb0;
    rgb_bits_t           pwm_rgb1;

    fb_port_if port0 ();   // upper half
    fb_port_if port1 ();   // lower half

    scan_counter i_scan_counter (
        .clk        (clk),
        .pll_locked (pll_locked),
        .step       (step),
        .scan_addr  (scan_addr),
        .row        (row),
        .steal      (steal),
        .threshold  (threshold)
    );

    fb_access i_fb_access (
        .clk        (clk),
        .pll_locked (pll_locked),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .scan_addr  (scan_addr),
        .steal      (steal),
        .port0      (port0.client),
        .port1      (port1.client),
        .pix0       (pix0),
        .pix1       (pix1)
    );

    fb_ram i_fb_ram0 (.clk(clk), .port(port0.mem));
    fb_ram i_fb_ram1 (.clk(clk), .port(port1.mem));

    pixel_pwm i_pixel_pwm (
        .pix0       (pix0),
        .pix1       (pix1),
        .threshold  (threshold),
        .steal      (steal),
        .rgb0       (pwm_rgb0),
        .rgb1       (pwm_rgb1)
    );

    panel_driver i_panel_driver (
        .clk        (clk),
        .pll_locked (pll_locked),
        .rgb0_in    (pwm_rgb0),
        .rgb1_in    (pwm_rgb1),
        .row_in     (row),
        .step       (step),
        .rgb0       (rgb0),
        .rgb1       (rgb1),
        .row_addr   (row_addr),
        .blank      (blank),
        .latch      (latch),
        .sclk       (sclk)
    );

endmodule

// File: hw/panel_driver.sv
`timescale 1ns/1ps

module panel_driver import panel_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,
    input  rgb_bits_t           rgb0_in,
    input  rgb_bits_t           rgb1_in,
    input  logic [row_bits-1:0] row_in,
    output logic                step,

    // panel pins, all registered
    output rgb_bits_t           rgb0,
    output rgb_bits_t           rgb1,
    output logic [row_bits-1:0] row_addr,
    output logic                blank,
    output logic                latch,
    output logic                sclk
);

    typedef enum logic [2:0] {
        ST_START,
        ST_DATA,     // column data out, sclk low
        ST_CLK,      // sclk high
        ST_BLANK,
        ST_LATCH,
        ST_UNBLANK
    } state_t;

    localparam logic [col_bits-1:0] last_col = col_bits'(cols - 1);

    state_t                  state;
    logic [col_bits-1:0]     col;         // column now on the pins
    logic [startup_bits-1:0] start_cnt;
    logic                    start_done;
    logic                    load_pixels;

    assign start_done = (state == ST_START) && (start_cnt == '0);

    // a step lands on the pins three cycles later, so run two columns ahead
    always_comb begin
        case (state)
            ST_START:   step = start_done;                // column 1 of row 0
            ST_CLK:     step = (col < col_bits'(cols - 2));
            ST_BLANK:   step = 1'b1;                      // column 0 of next row
            ST_UNBLANK: step = 1'b1;                      // column 1 of next row
            default:    step = 1'b0;
        endcase
    end

    // every entry into ST_DATA takes fresh column bits
    assign load_pixels = start_done
        || (state == ST_CLK && col != last_col)
        || (state == ST_UNBLANK);

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state     <= ST_START;
            start_cnt <= startup_bits'(startup_cycles - 1);
            col       <= '0;
            rgb0      <= '0;
            rgb1      <= '0;
            row_addr  <= '0;
            blank     <= 1'b1;   // dark until the first row is latched
            latch     <= 1'b0;
            sclk      <= 1'b0;
        end else begin
            if (load_pixels) begin
                rgb0 <= rgb0_in;
                rgb1 <= rgb1_in;
            end
            case (state)
                ST_START: begin
                    if (start_done) begin
                        state <= ST_DATA;
                    end else begin
                        start_cnt <= start_cnt - 1'b1;
                    end
                end
                ST_DATA: begin
                    sclk  <= 1'b1;
                    state <= ST_CLK;
                end
                ST_CLK: begin
                    sclk <= 1'b0;
                    col  <= col + 1'b1;   // wraps to 0 after the last column
                    if (col == last_col) begin
                        blank <= 1'b1;
                        state <= ST_BLANK;
                    end else begin
                        state <= ST_DATA;
                    end
                end
                ST_BLANK: begin
                    latch    <= 1'b1;
                    row_addr <= row_in;   // still the row just shifted
                    state    <= ST_LATCH;
                end
                ST_LATCH: begin
                    latch <= 1'b0;
                    blank <= 1'b0;
                    state <= ST_UNBLANK;
                end
                ST_UNBLANK: state <= ST_DATA;
                default:    state <= ST_START;
            endcase
        end
    end

endmodule

// File: hw/pixel_pwm.sv
`timescale 1ns/1ps

module pixel_pwm import panel_pkg::*; (
    input  pixel_t              pix0,
    input  pixel_t              pix1,
    input  logic [sub_bits-1:0] threshold,
    input  logic                steal,
    output rgb_bits_t           rgb0,
    output rgb_bits_t           rgb1
);

    // expand a 565 pixel and compare each channel against the threshold
    function automatic rgb_bits_t pwm_bits(pixel_t pix, logic [sub_bits-1:0] thr);
        logic [chan_bits-1:0] red8;
        logic [chan_bits-1:0] green8;
        logic [chan_bits-1:0] blue8;
        rgb_bits_t            bits;
        red8   = {pix.red, 3'b000};    // zero fill at the low end
        green8 = {pix.green, 2'b00};
        blue8  = {pix.blue, 3'b000};
        bits.r = red8 > thr;
        bits.g = green8 > thr;
        bits.b = blue8 > thr;
        return bits;
    endfunction

    rgb_bits_t lit0;
    rgb_bits_t lit1;

    assign lit0 = pwm_bits(pix0, threshold);
    assign lit1 = pwm_bits(pix1, threshold);

    // stolen subframe shows black
    assign rgb0 = steal ? rgb_bits_t'(0) : lit0;
    assign rgb1 = steal ? rgb_bits_t'(0) : lit1;

endmodule

// File: hw/scan_counter.sv
`timescale 1ns/1ps

module scan_counter import panel_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,
    input  logic                step,
    output fb_addr_t            scan_addr,
    output logic [row_bits-1:0] row,
    output logic                steal,
    output logic [sub_bits-1:0] threshold
);

    logic [col_bits-1:0] col;
    logic [sub_bits-1:0] subframe;

    // subframe, row and column form one counter
    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            subframe <= '0;
            row      <= '0;
            col      <= '0;
        end else if (step) begin
            {subframe, row, col} <= {subframe, row, col} + 1'b1;
        end
    end

    assign scan_addr = {row, col};

    // low subframe bits all ones
    assign steal = &subframe[steal_period_bits-1:0];

    // bit reversed so lit and dark subframes interleave finely
    always_comb begin
        for (int i = 0; i < sub_bits; i++) begin
            threshold[i] = subframe[sub_bits-1-i];
        end
    end

endmodule

// File: framebuffer/fb_access.sv
`timescale 1ns/1ps

module fb_access import panel_pkg::*; (
    input  logic             clk,
    input  logic             pll_locked,

    // APB slave
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  apb_addr_t        paddr,
    input  pixel_t           pwdata,
    output pixel_t           prdata,
    output logic             pready,

    input  fb_addr_t         scan_addr,
    input  logic             steal,

    fb_port_if.client        port0,
    fb_port_if.client        port1,
    output pixel_t           pix0,
    output pixel_t           pix1
);

    logic     half_sel;     // 1 selects the lower panel half
    fb_addr_t apb_word;
    logic     access;       // APB access phase
    logic     wr_go;
    logic     rd_issue;
    logic     rd_pending;   // RAM read issued last cycle

    assign half_sel = paddr[$bits(apb_addr_t)-1];
    assign apb_word = paddr[$bits(fb_addr_t)-1:0];
    assign access   = psel && penable;

    // a write lands in the first access cycle inside the steal window
    assign wr_go = access && pwrite && steal;

    // read goes out once, completes next cycle if the window is still open
    assign rd_issue = access && !pwrite && steal && !rd_pending;

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_issue;   // falls back to reissue if steal dropped
        end
    end

    assign pready = access && steal && (pwrite || rd_pending);
    assign prdata = half_sel ? port1.rdata : port0.rdata;

    // outside the window both halves follow the scan
    always_comb begin
        port0.addr  = steal ? apb_word : scan_addr;
        port1.addr  = steal ? apb_word : scan_addr;
        port0.wdata = pwdata;
        port1.wdata = pwdata;
        port0.wen   = wr_go && !half_sel;
        port1.wen   = wr_go && half_sel;
    end

    // pixel_pwm blanks these while steal is high
    assign pix0 = port0.rdata;
    assign pix1 = port1.rdata;

endmodule

// File: framebuffer/fb_ram.sv
`timescale 1ns/1ps

module fb_ram import panel_pkg::*; (
    input  logic   clk,
    fb_port_if.mem port
);

    pixel_t mem [0:fb_words-1];

    // registered read, old data on a write to the same word
    always_ff @(posedge clk) begin
        if (port.wen) begin
            mem[port.addr] <= port.wdata;
        end
        port.rdata <= mem[port.addr];
    end

endmodule

// File: common/fb_port_if.sv
`timescale 1ns/1ps

// one RAM half's port, shared by scan reads and APB access
interface fb_port_if import panel_pkg::*; ();

    fb_addr_t addr;
    pixel_t   wdata;
    logic     wen;
    pixel_t   rdata;   // word at last cycle's addr

    modport client (
        output addr,
        output wdata,
        output wen,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  wen,
        output rdata
    );

endinterface

// File: common/panel_pkg.sv
package panel_pkg;

    // panel geometry, one half of the 64x64 panel is 32 rows
    localparam int col_bits = 6;
    localparam int row_bits = 5;
    localparam int cols     = 1 << col_bits;

    localparam int sub_bits          = 8;  // pseudo-PWM depth
    localparam int steal_period_bits = 4;  // every 16th subframe is stolen
    localparam int chan_bits         = 8;  // colour channel after expansion

    // driver idles this long after reset before shifting
    localparam int startup_cycles = 16;
    localparam int startup_bits   = $clog2(startup_cycles);

    // RAM address of one half: row above column
    typedef logic [row_bits+col_bits-1:0] fb_addr_t;

    localparam int fb_words = 1 << $bits(fb_addr_t);

    // APB word address, top bit picks the half
    typedef logic [$bits(fb_addr_t):0] apb_addr_t;

    // RGB565
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // one shift bit per colour for a panel half
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_bits_t;

endpackage
